//--- sources.f
verilog/afifo_pkg.sv
verilog/gray_counter.sv
verilog/ptr_sync.sv
verilog/ram_t2p_asym.sv
verilog/fifo_write_ctrl.sv
verilog/fifo_read_ctrl.sv
verilog/fifo_async_asym.sv
dv/clk_gen.sv
dv/tb_fifo_async.sv

//--- run.sh
#!/bin/sh
# build and run the asymmetric async FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
   --top-module tb_fifo_async -f sources.f -o sim_fifo

status=0
./obj_dir/sim_fifo > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "CHECKS FAILED" sim.log || \
   ! grep -q "ALL CHECKS PASSED" sim.log; then
   echo "simulation failed, see sim.log"
   exit 1
fi
echo "simulation passed"

//--- dv/tb_fifo_async.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fifo_async;

   localparam int WAIT_LIMIT   = 100;
   localparam int RUN_LIMIT_NS = 200000;
   localparam int RAND_CYCLES  = 2000;

   logic                            rst;
   logic                            w_clk;
   logic                            w_en;
   logic [afifo_pkg::W_DATA_W-1:0]  w_data;
   logic                            w_full;
   logic                            w_empty;
   logic [afifo_pkg::ADDR_W:0]      w_level;
   logic                            r_clk;
   logic                            r_en;
   logic [afifo_pkg::R_DATA_W-1:0]  r_data;
   logic                            r_full;
   logic                            r_empty;
   logic [afifo_pkg::ADDR_W:0]      r_level;

   // reference model holds one entry per byte in read order
   logic [7:0]  exp_q [$];
   logic [7:0]  exp_byte;
   logic        cmp_pending = 1'b0;
   int          words_acc = 0;
   int          bytes_acc = 0;
   int          bytes_checked = 0;
   int          check_errors = 0;
   int          timeouts = 0;
   int          seed;

   clk_gen #(.PERIOD(4.0)) u_w_clk (.clk(w_clk));
   clk_gen #(.PERIOD(6.0)) u_r_clk (.clk(r_clk));

   fifo_async_asym dut (
      .rst     (rst),
      .w_clk   (w_clk),
      .w_en    (w_en),
      .w_data  (w_data),
      .w_full  (w_full),
      .w_empty (w_empty),
      .w_level (w_level),
      .r_clk   (r_clk),
      .r_en    (r_en),
      .r_data  (r_data),
      .r_full  (r_full),
      .r_empty (r_empty),
      .r_level (r_level)
   );

   // a word leaves the FIFO least significant byte first
   function automatic void push_model_word(input logic [31:0] word);
      for (int i = 0; i < 4; i++) begin
         exp_q.push_back(word[8*i +: 8]);
      end
   endfunction

   function automatic logic [7:0] pop_model_byte();
      return exp_q.pop_front();
   endfunction

   function automatic int expected_level();
      return 4 * words_acc - bytes_acc;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
         check_errors++;
      end
   endtask

   // one write attempt that is accepted at the edge after the flag is sampled low
   task automatic try_write(input logic [31:0] data, output bit accepted);
      @(posedge w_clk);
      #1;
      w_en   = 1'b1;
      w_data = data;
      @(negedge w_clk);
      accepted = !w_full;
      @(posedge w_clk);
      #1;
      w_en = 1'b0;
   endtask

   task automatic try_read(output bit accepted);
      @(posedge r_clk);
      #1;
      r_en = 1'b1;
      @(negedge r_clk);
      accepted = !r_empty;
      @(posedge r_clk);
      #1;
      r_en = 1'b0;
   endtask

   task automatic write_word(input logic [31:0] data);
      bit acc;
      int tries;
      acc   = 1'b0;
      tries = 0;
      while (!acc && tries < WAIT_LIMIT) begin
         try_write(data, acc);
         tries++;
      end
      if (!acc) begin
         $display("timeout: a write was never accepted");
         timeouts++;
      end
   endtask

   task automatic read_byte();
      bit acc;
      int tries;
      acc   = 1'b0;
      tries = 0;
      while (!acc && tries < WAIT_LIMIT) begin
         try_read(acc);
         tries++;
      end
      if (!acc) begin
         $display("timeout: no byte became readable");
         timeouts++;
      end
   endtask

   // both sides must reach the level implied by the accepted traffic
   task automatic settle_levels();
      int n;
      int lvl;
      lvl = expected_level();
      n   = 0;
      do begin
         @(negedge w_clk);
         n++;
      end while ((w_level != 7'(lvl) || r_level != 7'(lvl)) && n < WAIT_LIMIT);
      if (n >= WAIT_LIMIT) begin
         $display("timeout: levels did not settle after traffic stopped");
         timeouts++;
      end
      check_value("w_level", 32'(w_level), 32'(lvl));
      check_value("r_level", 32'(r_level), 32'(lvl));
      // the write side counts as full once fewer than 4 bytes are free
      @(negedge r_clk);
      check_value("w_empty", 32'(w_empty), 32'(lvl == 0));
      check_value("r_empty", 32'(r_empty), 32'(lvl == 0));
      check_value("w_full", 32'(w_full), 32'((64 - lvl) < 4));
      check_value("r_full", 32'(r_full), 32'(lvl == 64));
   endtask

   // inputs change 1 ns after a rising edge so the falling edge sees them stable
   always @(negedge w_clk) begin
      if (!rst && w_en && !w_full) begin
         push_model_word(w_data);
         words_acc++;
      end
   end

   // compare r_data one cycle after the edge that took the read
   always @(negedge r_clk) begin
      if (cmp_pending) begin
         assert (r_data === exp_byte) else begin
            $display("CHECK FAILED r_data got %h expected %h", r_data, exp_byte);
            check_errors++;
         end
         bytes_checked++;
      end
      cmp_pending = 1'b0;
      if (!rst && r_en && !r_empty) begin
         if (exp_q.size() == 0) begin
            $display("a read was accepted while the reference model held no byte");
            check_errors++;
         end else begin
            exp_byte    = pop_model_byte();
            cmp_pending = 1'b1;
         end
         bytes_acc++;
      end
   end

   initial begin : main
      int n;
      int tries;
      int t0;
      bit acc;
      bit stop;

      rst    = 1'b1;
      w_en   = 1'b0;
      w_data = '0;
      r_en   = 1'b0;
      seed   = 57;

      repeat (5) @(posedge r_clk);
      @(posedge w_clk);
      #1;
      // ST_INIT holds both flags high on each side
      check_value("w_full", 32'(w_full), 32'd1);
      check_value("w_empty", 32'(w_empty), 32'd1);
      check_value("r_full", 32'(r_full), 32'd1);
      check_value("r_empty", 32'(r_empty), 32'd1);
      rst = 1'b0;

      repeat (2) @(posedge r_clk);
      #1;
      check_value("w_empty", 32'(w_empty), 32'd1);
      check_value("w_full", 32'(w_full), 32'd0);
      check_value("r_empty", 32'(r_empty), 32'd1);
      check_value("r_full", 32'(r_full), 32'd0);
      check_value("w_level", 32'(w_level), 32'd0);
      check_value("r_level", 32'(r_level), 32'd0);

      // bytes 0 to 31 in order
      for (int i = 0; i < 8; i++) begin
         write_word(32'h03020100 + 32'(i) * 32'h04040404);
      end
      for (int i = 0; i < 32; i++) begin
         read_byte();
      end
      settle_levels();

      n     = 0;
      tries = 0;
      stop  = 1'b0;
      while (!stop && tries < WAIT_LIMIT) begin
         try_write(32'hF0E00000 | 32'(tries), acc);
         if (acc) n++;
         else stop = 1'b1;
         tries++;
      end
      if (!stop) begin
         $display("timeout: w_full never rose while filling");
         timeouts++;
      end
      check_value("fill word count", 32'(n), 32'd16);
      check_value("w_level", 32'(w_level), 32'd64);

      // a write against full leaves the FIFO untouched
      @(posedge w_clk);
      #1;
      w_en   = 1'b1;
      w_data = 32'hDEADBEEF;
      repeat (4) begin
         @(negedge w_clk);
         check_value("w_full", 32'(w_full), 32'd1);
         check_value("w_level", 32'(w_level), 32'd64);
      end
      @(posedge w_clk);
      #1;
      w_en = 1'b0;

      settle_levels();
      n     = 0;
      tries = 0;
      stop  = 1'b0;
      while (!stop && tries < 2 * WAIT_LIMIT) begin
         try_read(acc);
         if (acc) n++;
         else stop = 1'b1;
         tries++;
      end
      if (!stop) begin
         $display("timeout: r_empty never rose while draining");
         timeouts++;
      end
      check_value("drain byte count", 32'(n), 32'd64);

      // a read against empty must leave the next word intact
      @(posedge r_clk);
      #1;
      r_en = 1'b1;
      repeat (4) begin
         @(negedge r_clk);
         check_value("r_empty", 32'(r_empty), 32'd1);
         check_value("r_level", 32'(r_level), 32'd0);
      end
      @(posedge r_clk);
      #1;
      r_en = 1'b0;
      write_word(32'h44332211);
      repeat (4) read_byte();

      // partial traffic of 5 words in and 7 bytes out
      repeat (5) write_word($random(seed));
      repeat (7) read_byte();
      settle_levels();

      fork
         begin
            // dense writes fill the FIFO and sparse ones let it run dry
            for (int i = 0; i < RAND_CYCLES; i++) begin
               @(posedge w_clk);
               #1;
               if (i < RAND_CYCLES / 2) w_en = ($random(seed) & 7) == 0;
               else w_en = ($random(seed) & 15) == 0;
               w_data = $random(seed);
            end
            @(posedge w_clk);
            #1;
            w_en = 1'b0;
         end
         begin
            for (int i = 0; i < RAND_CYCLES; i++) begin
               @(posedge r_clk);
               #1;
               r_en = ($random(seed) & 1) == 1;
            end
            @(posedge r_clk);
            #1;
            r_en = 1'b0;
         end
      join

      // every byte left in the model still has to come out
      t0 = timeouts;
      while (exp_q.size() > 0 && timeouts == t0) begin
         read_byte();
      end
      @(negedge r_clk);
      settle_levels();

      $display("checks: %0d bytes compared, %0d errors, %0d timeouts",
               bytes_checked, check_errors, timeouts);
      if (check_errors == 0 && timeouts == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      #(RUN_LIMIT_NS);
      $display("simulation time limit reached before the tests finished");
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- dv/clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clk_gen #(
   parameter real PERIOD = 4.0
) (
   output logic clk
);

   // free running, low at time zero so the first rising edge is half a period in
   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD / 2.0);
         clk = ~clk;
      end
   end

endmodule

`default_nettype wire

//--- verilog/fifo_async_asym.sv
`timescale 1ns/100ps
`default_nettype none

module fifo_async_asym (
   input  logic                             rst,

   // write port
   input  logic                             w_clk,
   input  logic                             w_en,
   input  logic [afifo_pkg::W_DATA_W-1:0]   w_data,
   output logic                             w_full,
   output logic                             w_empty,
   output logic [afifo_pkg::ADDR_W:0]       w_level,

   // read port
   input  logic                             r_clk,
   input  logic                             r_en,
   output logic [afifo_pkg::R_DATA_W-1:0]   r_data,
   output logic                             r_full,
   output logic                             r_empty,
   output logic [afifo_pkg::ADDR_W:0]       r_level
);

   logic                             w_push;
   logic                             r_pop;
   logic [afifo_pkg::W_ADDR_W-1:0]   w_ptr_gray;
   logic [afifo_pkg::R_ADDR_W-1:0]   r_ptr_gray;
   logic [afifo_pkg::W_ADDR_W-1:0]   w_ptr_bin_rd;
   logic [afifo_pkg::R_ADDR_W-1:0]   r_ptr_bin_wr;
   logic [afifo_pkg::W_ADDR_W-1:0]   w_addr;
   logic [afifo_pkg::R_ADDR_W-1:0]   r_addr;

   // pointers, word steps on the write side and byte steps on the read side
   gray_counter #(.W(afifo_pkg::W_ADDR_W)) u_w_cnt (
      .clk  (w_clk),
      .rst  (rst),
      .en   (w_push),
      .gray (w_ptr_gray)
   );

   gray_counter #(.W(afifo_pkg::R_ADDR_W)) u_r_cnt (
      .clk  (r_clk),
      .rst  (rst),
      .en   (r_pop),
      .gray (r_ptr_gray)
   );

   // write pointer into r_clk
   ptr_sync #(.W(afifo_pkg::W_ADDR_W)) u_w2r_sync (
      .clk     (r_clk),
      .rst     (rst),
      .gray_in (w_ptr_gray),
      .bin_out (w_ptr_bin_rd)
   );

   // read pointer into w_clk
   ptr_sync #(.W(afifo_pkg::R_ADDR_W)) u_r2w_sync (
      .clk     (w_clk),
      .rst     (rst),
      .gray_in (r_ptr_gray),
      .bin_out (r_ptr_bin_wr)
   );

   fifo_write_ctrl u_w_ctrl (
      .w_clk      (w_clk),
      .rst        (rst),
      .w_en       (w_en),
      .w_ptr_gray (w_ptr_gray),
      .r_ptr_bin  (r_ptr_bin_wr),
      .w_push     (w_push),
      .w_addr     (w_addr),
      .w_full     (w_full),
      .w_empty    (w_empty),
      .w_level    (w_level)
   );

   fifo_read_ctrl u_r_ctrl (
      .r_clk      (r_clk),
      .rst        (rst),
      .r_en       (r_en),
      .r_ptr_gray (r_ptr_gray),
      .w_ptr_bin  (w_ptr_bin_rd),
      .r_pop      (r_pop),
      .r_addr     (r_addr),
      .r_full     (r_full),
      .r_empty    (r_empty),
      .r_level    (r_level)
   );

   ram_t2p_asym u_ram (
      .w_clk  (w_clk),
      .w_en   (w_push),
      .w_addr (w_addr),
      .w_data (w_data),
      .r_clk  (r_clk),
      .r_en   (r_pop),
      .r_addr (r_addr),
      .r_data (r_data)
   );

endmodule

`default_nettype wire

//--- verilog/fifo_read_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module fifo_read_ctrl (
   input  logic                             r_clk,
   input  logic                             rst,
   input  logic                             r_en,
   input  logic [afifo_pkg::R_ADDR_W-1:0]   r_ptr_gray,
   input  logic [afifo_pkg::W_ADDR_W-1:0]   w_ptr_bin,
   output logic                             r_pop,
   output logic [afifo_pkg::R_ADDR_W-1:0]   r_addr,
   output logic                             r_full,
   output logic                             r_empty,
   output logic [afifo_pkg::ADDR_W:0]       r_level
);

   afifo_pkg::fifo_state_t            st_q;
   afifo_pkg::fifo_state_t            st_nxt;
   afifo_pkg::ptr_t                   r_bin;
   logic [afifo_pkg::ADDR_W-1:0]      w_byte;
   logic [afifo_pkg::ADDR_W-1:0]      level_int;
   logic [afifo_pkg::ADDR_W:0]        level_ext;

   assign r_bin  = afifo_pkg::gray2bin(afifo_pkg::ptr_t'(r_ptr_gray));
   assign r_addr = r_bin[afifo_pkg::R_ADDR_W-1:0];

   // synchronized write pointer counts words, scale to bytes
   assign w_byte = {w_ptr_bin, {afifo_pkg::RATIO_W{1'b0}}};

   assign level_int = w_byte - r_addr;
   assign level_ext = {1'b0, level_int};

   assign r_empty = (st_q == afifo_pkg::ST_INIT) || (st_q == afifo_pkg::ST_EMPTY);
   assign r_pop   = r_en & ~r_empty;

   always_ff @(posedge r_clk) begin
      if (rst) begin
         st_q <= afifo_pkg::ST_INIT;
      end else begin
         st_q <= st_nxt;
      end
   end

   always_comb begin
      st_nxt  = st_q;
      r_full  = 1'b0;
      r_level = level_ext;
      case (st_q)
         afifo_pkg::ST_INIT: begin
            r_full = 1'b1;
            st_nxt = afifo_pkg::ST_EMPTY;
         end
         afifo_pkg::ST_EMPTY: begin
            if (level_ext >= afifo_pkg::R_INCR) begin
               st_nxt = afifo_pkg::ST_DEFAULT;
            end
         end
         default: begin
            // last byte going out
            if (r_pop && (level_ext - afifo_pkg::R_INCR) < afifo_pkg::R_INCR) begin
               st_nxt = afifo_pkg::ST_EMPTY;
            end
            // pointers equal outside the empty state means all 64 bytes present
            if (level_int == '0) begin
               r_full  = 1'b1;
               r_level = afifo_pkg::FIFO_SIZE;
            end
         end
      endcase
   end

   // read pointer holds while nothing can be popped
   a_no_pop_when_empty : assert property (
      @(posedge r_clk) disable iff (rst)
      r_empty |=> $stable(r_addr)
   );

endmodule

`default_nettype wire

//--- verilog/fifo_write_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module fifo_write_ctrl (
   input  logic                             w_clk,
   input  logic                             rst,
   input  logic                             w_en,
   input  logic [afifo_pkg::W_ADDR_W-1:0]   w_ptr_gray,
   input  logic [afifo_pkg::R_ADDR_W-1:0]   r_ptr_bin,
   output logic                             w_push,
   output logic [afifo_pkg::W_ADDR_W-1:0]   w_addr,
   output logic                             w_full,
   output logic                             w_empty,
   output logic [afifo_pkg::ADDR_W:0]       w_level
);

   afifo_pkg::fifo_state_t            st_q;
   afifo_pkg::fifo_state_t            st_nxt;
   afifo_pkg::ptr_t                   w_bin;
   logic [afifo_pkg::ADDR_W-1:0]      w_byte;
   logic [afifo_pkg::ADDR_W-1:0]      level_int;
   logic [afifo_pkg::ADDR_W:0]        level_ext;

   // own pointer back to binary, then scaled from words to bytes
   assign w_bin  = afifo_pkg::gray2bin(afifo_pkg::ptr_t'(w_ptr_gray));
   assign w_addr = w_bin[afifo_pkg::W_ADDR_W-1:0];
   assign w_byte = {w_addr, {afifo_pkg::RATIO_W{1'b0}}};

   // zero here is ambiguous, the state tells empty from full
   assign level_int = w_byte - r_ptr_bin;
   assign level_ext = {1'b0, level_int};

   assign w_full = (st_q == afifo_pkg::ST_INIT) || (st_q == afifo_pkg::ST_FULL);
   assign w_push = w_en & ~w_full;

   always_ff @(posedge w_clk) begin
      if (rst) begin
         st_q <= afifo_pkg::ST_INIT;
      end else begin
         st_q <= st_nxt;
      end
   end

   always_comb begin
      st_nxt  = st_q;
      w_empty = 1'b0;
      w_level = level_ext;
      case (st_q)
         afifo_pkg::ST_INIT: begin
            // one cycle with both flags up
            w_empty = 1'b1;
            st_nxt  = afifo_pkg::ST_DEFAULT;
         end
         afifo_pkg::ST_FULL: begin
            if (level_int == '0) begin
               w_level = afifo_pkg::FIFO_SIZE;
            end else if (level_ext <= afifo_pkg::FIFO_SIZE - afifo_pkg::W_INCR) begin
               st_nxt = afifo_pkg::ST_DEFAULT;
            end
         end
         default: begin
            if (level_int == '0) begin
               w_empty = 1'b1;
            end
            // not enough room left for another whole word
            if (w_push &&
                (level_ext + afifo_pkg::W_INCR) > (afifo_pkg::FIFO_SIZE - afifo_pkg::W_INCR)) begin
               st_nxt = afifo_pkg::ST_FULL;
            end
         end
      endcase
   end

   // a blocked write must not move the counter feeding w_addr
   a_no_push_when_full : assert property (
      @(posedge w_clk) disable iff (rst)
      w_full |=> $stable(w_addr)
   );

endmodule

`default_nettype wire

//--- verilog/ram_t2p_asym.sv
`timescale 1ns/100ps
`default_nettype none

module ram_t2p_asym (
   // write side, one full word per access
   input  logic                             w_clk,
   input  logic                             w_en,
   input  logic [afifo_pkg::W_ADDR_W-1:0]   w_addr,
   input  logic [afifo_pkg::W_DATA_W-1:0]   w_data,

   // read side, one byte per access
   input  logic                             r_clk,
   input  logic                             r_en,
   input  logic [afifo_pkg::R_ADDR_W-1:0]   r_addr,
   output logic [afifo_pkg::R_DATA_W-1:0]   r_data
);

   logic [afifo_pkg::RATIO_W-1:0]             r_lane;
   logic [afifo_pkg::W_ADDR_W-1:0]            r_word;
   logic [afifo_pkg::R_DATA_W-1:0]            lane_rd [afifo_pkg::LANES];

   // byte address splits into word row and lane select
   assign r_lane = r_addr[afifo_pkg::RATIO_W-1:0];
   assign r_word = r_addr[afifo_pkg::R_ADDR_W-1:afifo_pkg::RATIO_W];

   for (genvar l = 0; l < afifo_pkg::LANES; l++) begin : g_lane
      logic [afifo_pkg::R_DATA_W-1:0] mem [afifo_pkg::W_DEPTH];

      // lane 0 holds the least significant byte of each word
      always_ff @(posedge w_clk) begin
         if (w_en) begin
            mem[w_addr] <= w_data[l*afifo_pkg::R_DATA_W +: afifo_pkg::R_DATA_W];
         end
      end

      assign lane_rd[l] = mem[r_word];
   end

   // registered byte output, one r_clk after the accepted read
   always_ff @(posedge r_clk) begin
      if (r_en) begin
         r_data <= lane_rd[r_lane];
      end
   end

endmodule

`default_nettype wire

//--- verilog/ptr_sync.sv
`timescale 1ns/100ps
`default_nettype none

module ptr_sync #(
   parameter int W = 4
) (
   input  logic         clk,
   input  logic         rst,
   input  logic [W-1:0] gray_in,
   output logic [W-1:0] bin_out
);

   logic [W-1:0]     sync_0;
   logic [W-1:0]     sync_1;
   afifo_pkg::ptr_t  bin_ext;

   // two stages in the destination clock
   // gray_in is launched from the other domain, only here is it sampled
   always_ff @(posedge clk) begin
      if (rst) begin
         sync_0 <= '0;
         sync_1 <= '0;
      end else begin
         sync_0 <= gray_in;
         sync_1 <= sync_0;
      end
   end

   // convert after the second flop, never before the crossing
   assign bin_ext = afifo_pkg::gray2bin(afifo_pkg::ptr_t'(sync_1));
   assign bin_out = bin_ext[W-1:0];

endmodule

`default_nettype wire

//--- verilog/gray_counter.sv
`timescale 1ns/100ps
`default_nettype none

module gray_counter #(
   parameter int W = 4
) (
   input  logic         clk,
   input  logic         rst,
   input  logic         en,
   output logic [W-1:0] gray
);

   logic [W-1:0]     bin_q;
   logic [W-1:0]     bin_nxt;
   afifo_pkg::ptr_t  gray_nxt;

   assign bin_nxt  = bin_q + 1'b1;

   // zero extension keeps the upper gray bits at zero
   assign gray_nxt = afifo_pkg::bin2gray(afifo_pkg::ptr_t'(bin_nxt));

   // gray output comes straight from a flop so the crossing sees no glitches
   always_ff @(posedge clk) begin
      if (rst) begin
         bin_q <= '0;
         gray  <= '0;
      end else if (en) begin
         bin_q <= bin_nxt;
         gray  <= gray_nxt[W-1:0];
      end
   end

   // the synchronizer on the far side relies on single-bit steps
   a_gray_one_bit : assert property (
      @(posedge clk) disable iff (rst)
      $countones(gray ^ $past(gray)) <= 1
   );

endmodule

`default_nettype wire

//--- verilog/afifo_pkg.sv
`default_nettype none

package afifo_pkg;

   // port widths
   localparam int W_DATA_W = 32;
   localparam int R_DATA_W = 8;

   // byte addressing, 64 bytes deep
   localparam int ADDR_W   = 6;
   localparam int RATIO_W  = 2;
   localparam int W_ADDR_W = ADDR_W - RATIO_W;
   localparam int R_ADDR_W = ADDR_W;

   // memory organization
   localparam int LANES   = 1 << RATIO_W;
   localparam int W_DEPTH = 1 << W_ADDR_W;

   // level arithmetic is one bit wider than a byte pointer
   localparam logic [ADDR_W:0] FIFO_SIZE = 7'd64;
   localparam logic [ADDR_W:0] W_INCR    = 7'd4;
   localparam logic [ADDR_W:0] R_INCR    = 7'd1;

   typedef enum logic [1:0] {
      ST_INIT,
      ST_EMPTY,
      ST_DEFAULT,
      ST_FULL
   } fifo_state_t;

   // widest pointer, narrower pointers are zero extended into it
   typedef logic [ADDR_W-1:0] ptr_t;

   function automatic ptr_t bin2gray(input ptr_t bin);
      return bin ^ (bin >> 1);
   endfunction

   function automatic ptr_t gray2bin(input ptr_t gray);
      ptr_t bin;
      bin[ADDR_W-1] = gray[ADDR_W-1];
      // each binary bit folds in every gray bit above it
      for (int i = ADDR_W - 2; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

endpackage

`default_nettype wire
